/* source/rat_pkg.sv */
// shared widths, counts and reset values for the vector alias table
// packed types for rename slots, retire ports, read results and entry state

package rat_pkg;

  localparam int NUM_ENTRIES = 16;
  localparam int TILE_SIZE   = 8;
  localparam int NUM_TILES   = NUM_ENTRIES / TILE_SIZE;
  localparam int NUM_SLOTS   = 3;

  localparam int ADDR_W     = 6;
  localparam int IDX_W      = 4;
  localparam int TAG_W      = 9;
  localparam int DOM_W      = 2;
  localparam int TILE_IDX_W = $clog2(TILE_SIZE);

  typedef logic [ADDR_W-1:0] arch_addr_t;
  typedef logic [IDX_W-1:0]  entry_idx_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [DOM_W-1:0]  dom_t;

  // top two address bits equal to this mark a same-bundle dependency
  localparam logic [ADDR_W-IDX_W-1:0] DEP_PREFIX = 2'b11;

  localparam tag_t TAG_RESET  = '1;
  localparam dom_t DOM_RESET  = 2'd3;
  localparam dom_t DOMP_RESET = 2'd0;

  typedef struct packed {
    logic       valid;
    entry_idx_t dst;
    tag_t       tag;
    dom_t       dom;
  } rat_wr_t;

  typedef struct packed {
    logic       valid;
    tag_t       tag;
    entry_idx_t dst;
    dom_t       dom;
  } rat_ret_t;

  typedef struct packed {
    tag_t tag;
    logic retired;
    logic is_dep;
    dom_t dom;
  } rat_rd_t;

  typedef struct packed {
    tag_t tag;
    logic retired;
    dom_t dom;
  } entry_state_t;

endpackage

/* source/rat_entry.sv */
// one alias entry holding the newest producer tag, the retired flag
// and the speculative and committed domain, with write, retire and flush rules

`timescale 1ns/1ps

module rat_entry #(
  parameter int INDEX = 0
) (
  input  logic                                           clk,
  input  logic                                           rst,
  input  rat_pkg::rat_wr_t  [rat_pkg::NUM_SLOTS-1:0]     wr_hit,
  input  rat_pkg::rat_ret_t [rat_pkg::NUM_SLOTS-1:0]     ret,
  input  logic                                           retire_all,
  output rat_pkg::entry_state_t                          state
);

  rat_pkg::tag_t tag_q;
  logic          retired_q;
  rat_pkg::dom_t dom_q;
  rat_pkg::dom_t domp_q;

  logic          wr_match;
  rat_pkg::tag_t wr_tag;
  rat_pkg::dom_t wr_dom;
  logic          ret_match;
  logic          domp_load;
  rat_pkg::dom_t domp_new;

  // later slots override earlier ones, so the highest slot wins
  always_comb
  begin
    wr_match  = 1'b0;
    wr_tag    = tag_q;
    wr_dom    = dom_q;
    ret_match = 1'b0;
    domp_load = 1'b0;
    domp_new  = domp_q;
    for (int s = 0; s < rat_pkg::NUM_SLOTS; s++)
    begin
      if (wr_hit[s].valid && wr_hit[s].dst == rat_pkg::entry_idx_t'(INDEX))
      begin
        wr_match = 1'b1;
        wr_tag   = wr_hit[s].tag;
        wr_dom   = wr_hit[s].dom;
      end
      // retire by producer tag
      if (ret[s].valid && ret[s].tag == tag_q)
      begin
        ret_match = 1'b1;
      end
      // committed domain by architectural destination
      if (ret[s].valid && ret[s].dst == rat_pkg::entry_idx_t'(INDEX))
      begin
        domp_load = 1'b1;
        domp_new  = ret[s].dom;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag_q     <= rat_pkg::TAG_RESET;
      retired_q <= 1'b1;
      dom_q     <= rat_pkg::DOM_RESET;
      domp_q    <= rat_pkg::DOMP_RESET;
    end
    else
    begin
      if (wr_match)
      begin
        tag_q <= wr_tag;
      end
      // flush wins over a write for retired and domain, not for the tag
      if (retire_all)
      begin
        retired_q <= 1'b1;
        dom_q     <= domp_q;
      end
      else if (wr_match)
      begin
        retired_q <= 1'b0;
        dom_q     <= wr_dom;
      end
      else if (ret_match)
      begin
        retired_q <= 1'b1;
      end
      if (domp_load)
      begin
        domp_q <= domp_new;
      end
    end
  end

  assign state.tag     = tag_q;
  assign state.retired = retired_q;
  assign state.dom     = dom_q;

endmodule

/* source/rat_array.sv */
// the sixteen alias entries in two tiles of eight
// per-port read select picking the tile first and then the entry in it

`timescale 1ns/1ps

module rat_array (
  input  logic                                             clk,
  input  logic                                             rst,
  input  rat_pkg::rat_wr_t     [rat_pkg::NUM_SLOTS-1:0]    wr_hit,
  input  rat_pkg::rat_ret_t    [rat_pkg::NUM_SLOTS-1:0]    ret,
  input  logic                                             retire_all,
  input  rat_pkg::entry_idx_t  [rat_pkg::NUM_SLOTS-1:0]    rd_idx,
  output rat_pkg::entry_state_t [rat_pkg::NUM_SLOTS-1:0]   rd_state
);

  localparam int TILE_SEL_W = rat_pkg::IDX_W - rat_pkg::TILE_IDX_W;

  rat_pkg::entry_state_t ent_state [rat_pkg::NUM_TILES][rat_pkg::TILE_SIZE];

  for (genvar t = 0; t < rat_pkg::NUM_TILES; t++)
  begin : g_tile
    for (genvar e = 0; e < rat_pkg::TILE_SIZE; e++)
    begin : g_entry
      rat_entry #(
        .INDEX(t * rat_pkg::TILE_SIZE + e)
      ) u_entry (
        .clk       (clk),
        .rst       (rst),
        .wr_hit    (wr_hit),
        .ret       (ret),
        .retire_all(retire_all),
        .state     (ent_state[t][e])
      );
    end
  end

  // upper index bits pick the tile, lower bits the entry inside it
  for (genvar p = 0; p < rat_pkg::NUM_SLOTS; p++)
  begin : g_rd
    logic [TILE_SEL_W-1:0]          tile_sel;
    logic [rat_pkg::TILE_IDX_W-1:0] ent_sel;
    rat_pkg::entry_state_t          tile_rd [rat_pkg::TILE_SIZE];

    assign tile_sel = rd_idx[p][rat_pkg::IDX_W-1:rat_pkg::TILE_IDX_W];
    assign ent_sel  = rd_idx[p][rat_pkg::TILE_IDX_W-1:0];

    always_comb
    begin
      for (int e = 0; e < rat_pkg::TILE_SIZE; e++)
      begin
        tile_rd[e] = ent_state[tile_sel][e];
      end
    end

    assign rd_state[p] = tile_rd[ent_sel];
  end

endmodule

/* source/rat_read_sel.sv */
// read stage with captured read addresses, write slot qualification,
// same-bundle dependency bypass and final read result select

`timescale 1ns/1ps

module rat_read_sel (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              read_en,
  input  rat_pkg::arch_addr_t   [rat_pkg::NUM_SLOTS-1:0]    rd_addr,
  input  rat_pkg::rat_wr_t      [rat_pkg::NUM_SLOTS-1:0]    wr,
  output rat_pkg::rat_wr_t      [rat_pkg::NUM_SLOTS-1:0]    wr_hit,
  output rat_pkg::entry_idx_t   [rat_pkg::NUM_SLOTS-1:0]    rd_idx,
  input  rat_pkg::entry_state_t [rat_pkg::NUM_SLOTS-1:0]    rd_state,
  output rat_pkg::rat_rd_t      [rat_pkg::NUM_SLOTS-1:0]    rd_data
);

  rat_pkg::arch_addr_t [rat_pkg::NUM_SLOTS-1:0] rd_addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_addr_q <= '0;
    end
    else if (read_en)
    begin
      rd_addr_q <= rd_addr;
    end
  end

  // the bundle only renames when the stage is enabled
  always_comb
  begin
    for (int s = 0; s < rat_pkg::NUM_SLOTS; s++)
    begin
      wr_hit[s]       = wr[s];
      wr_hit[s].valid = wr[s].valid & read_en;
    end
  end

  always_comb
  begin
    for (int p = 0; p < rat_pkg::NUM_SLOTS; p++)
    begin
      rd_idx[p] = rd_addr_q[p][rat_pkg::IDX_W-1:0];
    end
  end

  always_comb
  begin
    for (int p = 0; p < rat_pkg::NUM_SLOTS; p++)
    begin
      rd_data[p] = '0;
      if (rd_addr_q[p][rat_pkg::ADDR_W-1:rat_pkg::IDX_W] == rat_pkg::DEP_PREFIX)
      begin
        // low bits name the producing slot of this bundle
        for (int s = 0; s < rat_pkg::NUM_SLOTS; s++)
        begin
          if (rd_addr_q[p][rat_pkg::IDX_W-1:0] == rat_pkg::IDX_W'(s))
          begin
            rd_data[p].tag     = wr[s].tag;
            rd_data[p].dom     = wr[s].dom;
            rd_data[p].retired = 1'b0;
            rd_data[p].is_dep  = 1'b1;
          end
        end
      end
      else if (rd_addr_q[p] < rat_pkg::ADDR_W'(rat_pkg::NUM_ENTRIES))
      begin
        rd_data[p].tag     = rd_state[p].tag;
        rd_data[p].retired = rd_state[p].retired;
        rd_data[p].dom     = rd_state[p].dom;
        rd_data[p].is_dep  = 1'b0;
      end
    end
  end

endmodule

/* source/vec_rat.sv */
// vector register alias table top level
// read stage plus the entry array, three ports each for rename, read and retire

`timescale 1ns/1ps

module vec_rat (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           read_en,
  input  rat_pkg::arch_addr_t [rat_pkg::NUM_SLOTS-1:0]   rd_addr,
  input  rat_pkg::rat_wr_t    [rat_pkg::NUM_SLOTS-1:0]   wr,
  input  rat_pkg::rat_ret_t   [rat_pkg::NUM_SLOTS-1:0]   ret,
  input  logic                                           retire_all,
  output rat_pkg::rat_rd_t    [rat_pkg::NUM_SLOTS-1:0]   rd_data
);

  rat_pkg::rat_wr_t      [rat_pkg::NUM_SLOTS-1:0] wr_hit;
  rat_pkg::entry_idx_t   [rat_pkg::NUM_SLOTS-1:0] rd_idx;
  rat_pkg::entry_state_t [rat_pkg::NUM_SLOTS-1:0] rd_state;

  rat_read_sel u_read_sel (
    .clk     (clk),
    .rst     (rst),
    .read_en (read_en),
    .rd_addr (rd_addr),
    .wr      (wr),
    .wr_hit  (wr_hit),
    .rd_idx  (rd_idx),
    .rd_state(rd_state),
    .rd_data (rd_data)
  );

  rat_array u_array (
    .clk       (clk),
    .rst       (rst),
    .wr_hit    (wr_hit),
    .ret       (ret),
    .retire_all(retire_all),
    .rd_idx    (rd_idx),
    .rd_state  (rd_state)
  );

endmodule

/* testbench/vec_rat_sva.sv */
// concurrent checks on the retired flag of one alias entry
// bound into every rat_entry instance

`timescale 1ns/1ps

module vec_rat_sva (
  input logic                  clk,
  input logic                  rst,
  input logic                  retire_all,
  input logic                  wr_match,
  input rat_pkg::entry_state_t state
);

  // flush marks the entry retired on the next cycle
  a_flush_retires: assert property (
    @(posedge clk) (!rst && retire_all) |=> state.retired
  )
  else $error("entry still not retired one cycle after retire_all");

  // a rename write without flush leaves the entry in flight
  a_write_clears: assert property (
    @(posedge clk) (!rst && wr_match && !retire_all) |=> !state.retired
  )
  else $error("entry still retired one cycle after a rename write");

endmodule

bind rat_entry vec_rat_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .retire_all(retire_all),
  .wr_match  (wr_match),
  .state     (state)
);

/* testbench/tb_rat_ref.svh */
// shadow copy of the alias entries and the captured read addresses
// ref_read forms the expected read result, advance_shadow steps the model one edge

`ifndef TB_RAT_REF_SVH
`define TB_RAT_REF_SVH

rat_pkg::tag_t       sh_tag     [rat_pkg::NUM_ENTRIES];
logic                sh_retired [rat_pkg::NUM_ENTRIES];
rat_pkg::dom_t       sh_dom     [rat_pkg::NUM_ENTRIES];
rat_pkg::dom_t       sh_domp    [rat_pkg::NUM_ENTRIES];
rat_pkg::arch_addr_t sh_addr    [rat_pkg::NUM_SLOTS];

// expected result of one read port from the model and the slots now on wr
function automatic rat_pkg::rat_rd_t ref_read(input int p);
  rat_pkg::rat_rd_t    res;
  rat_pkg::arch_addr_t a;
  int                  slot;
  res = '0;
  a   = sh_addr[p];
  if (a[rat_pkg::ADDR_W-1:rat_pkg::IDX_W] == rat_pkg::DEP_PREFIX)
  begin
    slot = int'(a[rat_pkg::IDX_W-1:0]);
    // a dependency on a slot number past the bundle reads as zero
    if (slot < rat_pkg::NUM_SLOTS)
    begin
      res.tag    = wr[slot].tag;
      res.dom    = wr[slot].dom;
      res.is_dep = 1'b1;
    end
  end
  else if (int'(a) < rat_pkg::NUM_ENTRIES)
  begin
    res.tag     = sh_tag[a[rat_pkg::IDX_W-1:0]];
    res.retired = sh_retired[a[rat_pkg::IDX_W-1:0]];
    res.dom     = sh_dom[a[rat_pkg::IDX_W-1:0]];
  end
  return res;
endfunction

// each entry only depends on its own old state, so it can be stepped in place
function automatic void advance_shadow();
  logic          hit;
  logic          tag_ret;
  rat_pkg::tag_t new_tag;
  rat_pkg::dom_t new_dom;
  rat_pkg::dom_t new_domp;
  for (int e = 0; e < rat_pkg::NUM_ENTRIES; e++)
  begin
    hit      = 1'b0;
    tag_ret  = 1'b0;
    new_tag  = sh_tag[e];
    new_dom  = sh_dom[e];
    new_domp = sh_domp[e];
    for (int s = 0; s < rat_pkg::NUM_SLOTS; s++)
    begin
      if (read_en && wr[s].valid && int'(wr[s].dst) == e)
      begin
        hit     = 1'b1;
        new_tag = wr[s].tag;
        new_dom = wr[s].dom;
      end
      if (ret[s].valid && ret[s].tag == sh_tag[e])
      begin
        tag_ret = 1'b1;
      end
      if (ret[s].valid && int'(ret[s].dst) == e)
      begin
        new_domp = ret[s].dom;
      end
    end
    if (rst)
    begin
      sh_tag[e]     = rat_pkg::TAG_RESET;
      sh_retired[e] = 1'b1;
      sh_dom[e]     = rat_pkg::DOM_RESET;
      sh_domp[e]    = rat_pkg::DOMP_RESET;
    end
    else
    begin
      if (retire_all)
      begin
        sh_retired[e] = 1'b1;
        sh_dom[e]     = sh_domp[e];
      end
      else if (hit)
      begin
        sh_retired[e] = 1'b0;
        sh_dom[e]     = new_dom;
      end
      else if (tag_ret)
      begin
        sh_retired[e] = 1'b1;
      end
      sh_tag[e]  = new_tag;
      sh_domp[e] = new_domp;
    end
  end
  for (int p = 0; p < rat_pkg::NUM_SLOTS; p++)
  begin
    if (rst)
    begin
      sh_addr[p] = '0;
    end
    else if (read_en)
    begin
      sh_addr[p] = rd_addr[p];
    end
  end
endfunction

`endif

/* testbench/tb_vec_rat.sv */
// testbench for the vector alias table
// clock, reset, directed and random rename/read/retire traffic,
// per-cycle comparison against the shadow model and a cycle timeout

`timescale 1ns/1ps

module tb_vec_rat;

  localparam int RESET_CYCLES   = 8;
  localparam int RAND_CYCLES    = 2000;
  // headroom over reset, the short directed part and the random run
  localparam int TIMEOUT_CYCLES = RAND_CYCLES + RAND_CYCLES / 2;

  logic                                            clk;
  logic                                            rst;
  logic                                            read_en;
  rat_pkg::arch_addr_t [rat_pkg::NUM_SLOTS-1:0]    rd_addr;
  rat_pkg::rat_wr_t    [rat_pkg::NUM_SLOTS-1:0]    wr;
  rat_pkg::rat_ret_t   [rat_pkg::NUM_SLOTS-1:0]    ret;
  logic                                            retire_all;
  rat_pkg::rat_rd_t    [rat_pkg::NUM_SLOTS-1:0]    rd_data;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  `include "tb_rat_ref.svh"

  vec_rat dut0 (
    .clk       (clk),
    .rst       (rst),
    .read_en   (read_en),
    .rd_addr   (rd_addr),
    .wr        (wr),
    .ret       (ret),
    .retire_all(retire_all),
    .rd_data   (rd_data)
  );

  always #10 clk = ~clk;

  function automatic rat_pkg::rat_wr_t wr_slot(input int valid, input int dst,
                                               input int tag, input int dom);
    rat_pkg::rat_wr_t res;
    res.valid = (valid != 0);
    res.dst   = rat_pkg::entry_idx_t'(dst);
    res.tag   = rat_pkg::tag_t'(tag);
    res.dom   = rat_pkg::dom_t'(dom);
    return res;
  endfunction

  function automatic rat_pkg::rat_ret_t ret_port(input int valid, input int tag,
                                                 input int dst, input int dom);
    rat_pkg::rat_ret_t res;
    res.valid = (valid != 0);
    res.tag   = rat_pkg::tag_t'(tag);
    res.dst   = rat_pkg::entry_idx_t'(dst);
    res.dom   = rat_pkg::dom_t'(dom);
    return res;
  endfunction

  function automatic rat_pkg::arch_addr_t entry_addr(input int n);
    return rat_pkg::arch_addr_t'(n % rat_pkg::NUM_ENTRIES);
  endfunction

  task automatic apply_cycle(input logic en,
                             input rat_pkg::arch_addr_t [rat_pkg::NUM_SLOTS-1:0] addr,
                             input rat_pkg::rat_wr_t    [rat_pkg::NUM_SLOTS-1:0] w,
                             input rat_pkg::rat_ret_t   [rat_pkg::NUM_SLOTS-1:0] r,
                             input logic flush);
    @(posedge clk);
    read_en    <= en;
    rd_addr    <= addr;
    wr         <= w;
    ret        <= r;
    retire_all <= flush;
  endtask

  // retire tags are drawn half from live entry tags so that tag matches happen
  task automatic rand_cycle();
    rat_pkg::arch_addr_t [rat_pkg::NUM_SLOTS-1:0] a;
    rat_pkg::rat_wr_t    [rat_pkg::NUM_SLOTS-1:0] w;
    rat_pkg::rat_ret_t   [rat_pkg::NUM_SLOTS-1:0] r;
    int                                           pick;
    int                                           tag;
    for (int s = 0; s < rat_pkg::NUM_SLOTS; s++)
    begin
      pick = int'($urandom_range(99));
      if (pick < 70)
        a[s] = entry_addr(int'($urandom_range(15)));
      else if (pick < 85)
        a[s] = rat_pkg::arch_addr_t'(48 + $urandom_range(15));
      else
        a[s] = rat_pkg::arch_addr_t'(16 + $urandom_range(31));
      w[s] = wr_slot(int'($urandom_range(1)), int'($urandom_range(15)),
                     int'($urandom_range(511)), int'($urandom_range(3)));
      if ($urandom_range(1) == 1)
        tag = int'(sh_tag[rat_pkg::entry_idx_t'($urandom_range(15))]);
      else
        tag = int'($urandom_range(511));
      r[s] = ret_port(int'($urandom_range(1)), tag, int'($urandom_range(15)),
                      int'($urandom_range(3)));
    end
    apply_cycle($urandom_range(99) < 85, a, w, r, $urandom_range(99) < 3);
  endtask

  // compare at the falling edge, then step the model over the next rising edge
  always @(negedge clk)
  begin
    rat_pkg::rat_rd_t exp_rd;
    if (!rst)
    begin
      for (int p = 0; p < rat_pkg::NUM_SLOTS; p++)
      begin
        exp_rd = ref_read(p);
        checks++;
        assert (rd_data[p] === exp_rd)
        else
        begin
          errors++;
          $display("ERROR rd_data[%0d] got %h expected %h at cycle %0d",
                   p, rd_data[p], exp_rd, cycles);
        end
      end
    end
    advance_shadow();
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'hf1c5));
    clk        = 1'b0;
    rst        = 1'b1;
    read_en    = 1'b0;
    rd_addr    = '0;
    wr         = '0;
    ret        = '0;
    retire_all = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // reset contents of all sixteen entries
    for (int i = 0; i < 6; i++)
    begin
      apply_cycle(1'b1, {entry_addr(3 * i + 2), entry_addr(3 * i + 1), entry_addr(3 * i)},
                  '0, '0, 1'b0);
    end

    // slots 0 and 1 both rename entry 5
    apply_cycle(1'b1, {6'd9, 6'd5, 6'd5},
                {wr_slot(1, 9, 'h1a3, 2), wr_slot(1, 5, 'h0f1, 1), wr_slot(1, 5, 'h055, 0)},
                '0, 1'b0);
    apply_cycle(1'b1, {6'd9, 6'd5, 6'd0}, '0, '0, 1'b0);
    apply_cycle(1'b1, {6'd9, 6'd5, 6'd0}, '0,
                {ret_port(0, 0, 0, 0), ret_port(0, 0, 0, 0), ret_port(1, 'h0f1, 5, 1)}, 1'b0);
    // write and tag retire meet on entry 9
    apply_cycle(1'b1, {6'd9, 6'd5, 6'd9},
                {wr_slot(0, 0, 0, 0), wr_slot(0, 0, 0, 0), wr_slot(1, 9, 'h0aa, 3)},
                {ret_port(0, 0, 0, 0), ret_port(1, 'h1a3, 9, 2), ret_port(0, 0, 0, 0)}, 1'b0);
    apply_cycle(1'b1, {6'd9, 6'd5, 6'd9}, '0, '0, 1'b0);

    // same-bundle dependencies and addresses past the table
    apply_cycle(1'b1, {6'd50, 6'd49, 6'd48},
                {wr_slot(1, 3, 'h111, 1), wr_slot(0, 4, 'h122, 2), wr_slot(1, 7, 'h133, 3)},
                '0, 1'b0);
    apply_cycle(1'b1, {6'd47, 6'd31, 6'd16},
                {wr_slot(1, 12, 'h144, 0), wr_slot(1, 13, 'h155, 1), wr_slot(1, 14, 'h166, 2)},
                '0, 1'b0);
    apply_cycle(1'b1, {6'd63, 6'd20, 6'd3}, '0, '0, 1'b0);

    // committed domains, then a flush and a full read back
    for (int i = 0; i < 6; i++)
    begin
      apply_cycle(1'b1, '0, '0,
                  {ret_port(1, 'h1f0 + i, 3 * i + 2, i + 1),
                   ret_port(1, 'h1e0 + i, 3 * i + 1, i + 2),
                   ret_port(1, 'h1d0 + i, 3 * i, i + 3)}, 1'b0);
    end
    apply_cycle(1'b1, '0, '0, '0, 1'b1);
    for (int i = 0; i < 6; i++)
    begin
      apply_cycle(1'b1, {entry_addr(3 * i + 2), entry_addr(3 * i + 1), entry_addr(3 * i)},
                  '0, '0, 1'b0);
    end

    // with the stage disabled the writes are dropped and the old addresses kept
    apply_cycle(1'b1, {6'd2, 6'd1, 6'd0}, '0, '0, 1'b0);
    repeat (3)
    begin
      apply_cycle(1'b0, {6'd15, 6'd14, 6'd13},
                  {wr_slot(1, 2, 'h0c2, 1), wr_slot(1, 1, 'h0c1, 2), wr_slot(1, 0, 'h0c0, 3)},
                  '0, 1'b0);
    end

    repeat (RAND_CYCLES) rand_cycle();
    apply_cycle(1'b0, '0, '0, '0, 1'b0);
    repeat (2) @(posedge clk);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* all.f */
+incdir+testbench
source/rat_pkg.sv
source/rat_entry.sv
source/rat_array.sv
source/rat_read_sel.sv
source/vec_rat.sv
testbench/vec_rat_sva.sv
testbench/tb_vec_rat.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_vec_rat
FILELIST  := all.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
